// File: gamePkg.sv
package gamePkg;

	// visible frame in pixels
	localparam int FRAME_WIDTH = 640;
	localparam int FRAME_HEIGHT = 480;

	localparam int TILE_SIZE = 16; // tile edge in pixels

	// map geometry in tiles
	localparam int MAP_COLS = 40;
	localparam int MAP_ROWS = 30;
	localparam int MAP_DEPTH = MAP_COLS * MAP_ROWS; // 1200 entries
	localparam int MAP_ADDR_WIDTH = 11;

	// codes 2 and 3 are reserved and render as free
	localparam logic [1:0] TILE_FREE = 2'd0;
	localparam logic [1:0] TILE_BRICK = 2'd1;

	localparam logic [7:0] TRANSPARENT_COLOR = 8'hFF; // pixel outside the frame

	// one pixel coordinate read as a raw count or as tile index over offset
	typedef union packed {
		logic [10:0] raw;
		struct packed {
			logic [6:0] tile; // coordinate / TILE_SIZE
			logic [3:0] offset; // coordinate % TILE_SIZE
		} split;
	} pixelCoord_t;

	// outer wall plus a pillar every fourth tile
	function automatic logic [1:0] startTile(input int row, input int col);
		logic border;
		logic pillar;
		border = (col == 0) || (col == MAP_COLS - 1) ||
			(row == 0) || (row == MAP_ROWS - 1);
		pillar = ((col % 4) == 2) && ((row % 4) == 2);
		if (border || pillar)
		begin
			return TILE_BRICK;
		end
		else
		begin
			return TILE_FREE;
		end
	endfunction

endpackage

// File: tileMapRam.sv
module tileMapRam (
	input logic clk,
	input logic resetN,
	input logic [gamePkg::MAP_ADDR_WIDTH-1:0] addr,
	input logic writeEn,
	input logic [1:0] writeData,
	output logic [1:0] tileData
);

	// one 2-bit tile code per entry at row * MAP_COLS + col
	logic [1:0] mapMem [gamePkg::MAP_DEPTH];
	logic inRange;

	assign inRange = (addr < gamePkg::MAP_DEPTH); // addresses 1200..2047 do not exist

	// every reset rebuilds the maze so a new game starts with all bricks back
	always_ff @(posedge clk or negedge resetN)
	begin
		if (!resetN)
		begin
			for (int row = 0; row < gamePkg::MAP_ROWS; row++)
			begin
				for (int col = 0; col < gamePkg::MAP_COLS; col++)
				begin
					mapMem[row * gamePkg::MAP_COLS + col] <= gamePkg::startTile(row, col);
				end
			end
		end
		else if (writeEn && inRange)
		begin
			mapMem[addr] <= writeData; // lands on the granted edge
		end
	end

	// combinational read so the renderer sees the tile in the same cycle
	always_comb
	begin
		if (inRange)
		begin
			tileData = mapMem[addr];
		end
		else
		begin
			tileData = gamePkg::TILE_FREE; // nothing drawn off the map
		end
	end

endmodule

// File: mapArbiter.sv
module mapArbiter (
	// renderer side
	input logic readReq,
	input logic [gamePkg::MAP_ADDR_WIDTH-1:0] readAddr,

	// eraser side
	input logic writeReq,
	input logic [gamePkg::MAP_ADDR_WIDTH-1:0] writeAddr,
	output logic writeGrant,

	// shared tile map port
	output logic [gamePkg::MAP_ADDR_WIDTH-1:0] addr,
	output logic writeEn,
	output logic [1:0] writeData
);

	// renderer owns the map for every visible pixel and the eraser waits for blanking
	assign writeGrant = writeReq && !readReq;

	always_comb
	begin
		if (writeGrant)
		begin
			addr = writeAddr; // erase address during blanking
			writeEn = 1'b1;
		end
		else
		begin
			addr = readAddr; // renderer lookup
			writeEn = 1'b0;
		end
	end

	assign writeData = gamePkg::TILE_FREE; // erasing only ever clears a tile

endmodule

// File: brickRenderer.sv
module brickRenderer #(
	parameter logic [7:0] brickColor = 8'h5B
) (
	input logic clk,
	input logic resetN,
	input logic [10:0] pixelX, // current VGA pixel
	input logic [10:0] pixelY,
	input logic [1:0] tileData, // from the tile map, same cycle

	output logic readReq,
	output logic [gamePkg::MAP_ADDR_WIDTH-1:0] readAddr,

	output logic drawingRequest, // pixel lies on a brick
	output logic [3:0] offsetX, // offset inside the tile
	output logic [3:0] offsetY,
	output logic [7:0] rgbOut
);

	gamePkg::pixelCoord_t xCoord;
	gamePkg::pixelCoord_t yCoord;
	logic insideFrame;
	int tileIndex;

	assign xCoord.raw = pixelX;
	assign yCoord.raw = pixelY;

	assign insideFrame = (pixelX < gamePkg::FRAME_WIDTH) && (pixelY < gamePkg::FRAME_HEIGHT);

	// tile column and row come straight out of the upper coordinate bits
	assign tileIndex = int'(yCoord.split.tile) * gamePkg::MAP_COLS + int'(xCoord.split.tile);
	assign readAddr = tileIndex[gamePkg::MAP_ADDR_WIDTH-1:0];

	assign readReq = insideFrame; // holds the map for the whole visible line

	always_ff @(posedge clk or negedge resetN)
	begin
		if (!resetN)
		begin
			drawingRequest <= 1'b0;
			offsetX <= 4'd0;
			offsetY <= 4'd0;
			rgbOut <= 8'd0;
		end
		else if (insideFrame)
		begin
			drawingRequest <= (tileData == gamePkg::TILE_BRICK); // reserved codes not drawn
			offsetX <= xCoord.split.offset;
			offsetY <= yCoord.split.offset;
			rgbOut <= brickColor;
		end
		else
		begin
			drawingRequest <= 1'b0; // blanking
			offsetX <= 4'd0;
			offsetY <= 4'd0;
			rgbOut <= gamePkg::TRANSPARENT_COLOR;
		end
	end

endmodule

// File: brickEraser.sv
module brickEraser (
	input logic clk,
	input logic resetN,
	input logic hitStrobe, // one-cycle hit from game logic
	input logic [5:0] hitCol,
	input logic [4:0] hitRow,
	input logic writeGrant,

	output logic writeReq, // held until the arbiter grants
	output logic [gamePkg::MAP_ADDR_WIDTH-1:0] writeAddr,
	output logic eraseDone // pulses the cycle after the write
);

	int hitIndex;
	logic acceptHit;

	assign hitIndex = int'(hitRow) * gamePkg::MAP_COLS + int'(hitCol);
	assign acceptHit = hitStrobe && !writeReq; // a second hit while pending is dropped

	always_ff @(posedge clk or negedge resetN)
	begin
		if (!resetN)
		begin
			writeReq <= 1'b0;
			eraseDone <= 1'b0;
		end
		else
		begin
			eraseDone <= writeReq && writeGrant; // write happened on this edge
			if (acceptHit)
			begin
				writeReq <= 1'b1;
			end
			else if (writeGrant)
			begin
				writeReq <= 1'b0;
			end
		end
	end

	// address stays frozen while the request waits for blanking
	always_ff @(posedge clk)
	begin
		if (acceptHit)
		begin
			writeAddr <= hitIndex[gamePkg::MAP_ADDR_WIDTH-1:0];
		end
	end

endmodule

// File: mazeDisplay.sv
module mazeDisplay #(
	parameter logic [7:0] brickColor = 8'h5B
) (
	input logic clk,
	input logic resetN,
	input logic [10:0] pixelX,
	input logic [10:0] pixelY,
	input logic hitStrobe,
	input logic [5:0] hitCol,
	input logic [4:0] hitRow,

	output logic drawingRequest,
	output logic [3:0] offsetX,
	output logic [3:0] offsetY,
	output logic [7:0] rgbOut,
	output logic eraseDone
);

	logic readReq;
	logic [gamePkg::MAP_ADDR_WIDTH-1:0] readAddr;
	logic writeReq;
	logic [gamePkg::MAP_ADDR_WIDTH-1:0] writeAddr;
	logic writeGrant;
	logic [gamePkg::MAP_ADDR_WIDTH-1:0] addr; // shared map port
	logic writeEn;
	logic [1:0] writeData;
	logic [1:0] tileData;

	brickRenderer #(
		.brickColor(brickColor)
	) renderer_i (
		.clk(clk),
		.resetN(resetN),
		.pixelX(pixelX),
		.pixelY(pixelY),
		.tileData(tileData),
		.readReq(readReq),
		.readAddr(readAddr),
		.drawingRequest(drawingRequest),
		.offsetX(offsetX),
		.offsetY(offsetY),
		.rgbOut(rgbOut)
	);

	brickEraser eraser_i (
		.clk(clk),
		.resetN(resetN),
		.hitStrobe(hitStrobe),
		.hitCol(hitCol),
		.hitRow(hitRow),
		.writeGrant(writeGrant),
		.writeReq(writeReq),
		.writeAddr(writeAddr),
		.eraseDone(eraseDone)
	);

	mapArbiter arbiter_i (
		.readReq(readReq),
		.readAddr(readAddr),
		.writeReq(writeReq),
		.writeAddr(writeAddr),
		.writeGrant(writeGrant),
		.addr(addr),
		.writeEn(writeEn),
		.writeData(writeData)
	);

	tileMapRam map_i (
		.clk(clk),
		.resetN(resetN),
		.addr(addr),
		.writeEn(writeEn),
		.writeData(writeData),
		.tileData(tileData)
	);

endmodule

// File: mazeDisplay_sva.sv
module mazeDisplay_sva (
	input logic clk,
	input logic resetN,
	input logic [10:0] pixelX,
	input logic [10:0] pixelY,
	input logic readReq,
	input logic writeGrant,
	input logic drawingRequest,
	input logic [7:0] rgbOut
);

	timeunit 1ns;
	timeprecision 1ps;

	int assertFails = 0;
	logic outsideFrame;

	assign outsideFrame = (pixelX >= gamePkg::FRAME_WIDTH) || (pixelY >= gamePkg::FRAME_HEIGHT);

	// eraser gets the map only while the renderer is idle
	grantInBlanking: assert property (@(posedge clk) disable iff (!resetN)
		$rose(writeGrant) |-> !readReq)
	else
	begin
		$error("writeGrant rose while readReq was high");
		assertFails++;
	end

	// blanking pixel never draws
	noDrawOutside: assert property (@(posedge clk) disable iff (!resetN)
		outsideFrame |=> !drawingRequest)
	else
	begin
		$error("drawingRequest high after an out-of-frame pixel");
		assertFails++;
	end

	transparentOutside: assert property (@(posedge clk) disable iff (!resetN)
		outsideFrame |=> (rgbOut == gamePkg::TRANSPARENT_COLOR))
	else
	begin
		$error("rgbOut not transparent after an out-of-frame pixel");
		assertFails++;
	end

endmodule

// top level sees both the arbiter grant and the renderer outputs
bind mazeDisplay mazeDisplay_sva sva_i (
	.clk(clk),
	.resetN(resetN),
	.pixelX(pixelX),
	.pixelY(pixelY),
	.readReq(readReq),
	.writeGrant(writeGrant),
	.drawingRequest(drawingRequest),
	.rgbOut(rgbOut)
);

// File: mazeDisplay_tb.sv
module mazeDisplay_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam logic [7:0] BRICK_COLOR = 8'h5B;
	localparam int TIMEOUT_CYCLES = 50;
	localparam int QUIET_CYCLES = 8; // cycles a hit must stay pending while pixels are visible

	logic clk;
	logic resetN;
	logic [10:0] pixelX;
	logic [10:0] pixelY;
	logic hitStrobe;
	logic [5:0] hitCol;
	logic [4:0] hitRow;
	logic drawingRequest;
	logic [3:0] offsetX;
	logic [3:0] offsetY;
	logic [7:0] rgbOut;
	logic eraseDone;

	logic [1:0] modelMap [gamePkg::MAP_DEPTH]; // reference copy of the tile map
	logic erasePending;
	int pendingAddr;
	int testErrors;
	int passCount;
	int failCount;
	int otherErrors;

	mazeDisplay #(
		.brickColor(BRICK_COLOR)
	) dut_i (
		.clk(clk),
		.resetN(resetN),
		.pixelX(pixelX),
		.pixelY(pixelY),
		.hitStrobe(hitStrobe),
		.hitCol(hitCol),
		.hitRow(hitRow),
		.drawingRequest(drawingRequest),
		.offsetX(offsetX),
		.offsetY(offsetY),
		.rgbOut(rgbOut),
		.eraseDone(eraseDone)
	);

	initial
	begin
		clk = 1'b0;
		forever
		begin
			#2 clk = ~clk;
		end
	end

	// outer wall plus a pillar at every column and row that is 2 mod 4
	function automatic logic [1:0] mazeStartCode(input int row, input int col);
		logic wall;
		wall = (col == 0) || (col == 39) || (row == 0) || (row == 29);
		if (wall || ((col % 4 == 2) && (row % 4 == 2)))
		begin
			return 2'd1;
		end
		return 2'd0;
	endfunction

	task automatic compareSignal(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected)
		begin
			$display("FAILED t=%0t %s got 0x%0h expected 0x%0h", $time, name, got, expected);
			testErrors++;
		end
	endtask

	// compares the trace record with the model, then the DUT with the model
	task automatic checkOutputs(input int x, input int y, input int trDraw, input int trOffX,
		input int trOffY, input int trColor);
		gamePkg::pixelCoord_t xc;
		gamePkg::pixelCoord_t yc;
		int expDraw;
		int expOffX;
		int expOffY;
		int expColor;
		xc.raw = x[10:0];
		yc.raw = y[10:0];
		expDraw = 0;
		expOffX = 0;
		expOffY = 0;
		expColor = gamePkg::TRANSPARENT_COLOR;
		if ((x < gamePkg::FRAME_WIDTH) && (y < gamePkg::FRAME_HEIGHT))
		begin
			expDraw = (modelMap[int'(yc.split.tile) * gamePkg::MAP_COLS + int'(xc.split.tile)]
				== gamePkg::TILE_BRICK);
			expOffX = xc.split.offset;
			expOffY = yc.split.offset;
			expColor = BRICK_COLOR;
		end
		if ((trDraw != expDraw) || (trOffX != expOffX) || (trOffY != expOffY) ||
			(trColor != expColor))
		begin
			$display("trace record for pixel %0d,%0d disagrees with the tile map model", x, y);
			testErrors++;
		end
		compareSignal("drawingRequest", drawingRequest, expDraw);
		compareSignal("offsetX", offsetX, expOffX);
		compareSignal("offsetY", offsetY, expOffY);
		compareSignal("rgbOut", rgbOut, expColor);
	endtask

	task automatic applyPixel(input int x, input int y, input int d, input int ox, input int oy,
		input int c);
		@(negedge clk);
		pixelX = x[10:0];
		pixelY = y[10:0];
		@(negedge clk); // one cycle of latency
		checkOutputs(x, y, d, ox, oy, c);
		compareSignal("eraseDone", eraseDone, 0);
	endtask

	task automatic applyHit(input int col, input int row, input int d, input int ox, input int oy,
		input int c);
		@(negedge clk);
		hitCol = col[5:0];
		hitRow = row[4:0];
		hitStrobe = 1'b1;
		@(negedge clk);
		hitStrobe = 1'b0;
		if (!erasePending)
		begin
			erasePending = 1'b1; // a hit while one is pending is dropped
			pendingAddr = row * gamePkg::MAP_COLS + col;
		end
		for (int i = 0; i < QUIET_CYCLES; i++)
		begin
			if (eraseDone)
			begin
				$display("eraseDone pulsed at %0t while the pixel was inside the frame", $time);
				testErrors++;
			end
			@(negedge clk);
		end
		checkOutputs(pixelX, pixelY, d, ox, oy, c); // held pixel still renders
	endtask

	task automatic moveOut(input int x, input int y, input int d, input int ox, input int oy,
		input int c);
		int waited;
		@(negedge clk);
		pixelX = x[10:0];
		pixelY = y[10:0];
		@(negedge clk);
		if (erasePending)
		begin
			waited = 0;
			while (!eraseDone && (waited < TIMEOUT_CYCLES))
			begin
				@(negedge clk);
				waited++;
			end
			if (!eraseDone)
			begin
				$display("timeout: eraseDone did not pulse within %0d cycles of blanking",
					TIMEOUT_CYCLES);
				testErrors++;
			end
			else
			begin
				modelMap[pendingAddr] = gamePkg::TILE_FREE;
				@(negedge clk);
				if (eraseDone)
				begin
					$display("eraseDone stayed high for more than one cycle at %0t", $time);
					testErrors++;
				end
			end
			erasePending = 1'b0;
		end
		checkOutputs(x, y, d, ox, oy, c);
	endtask

	task automatic reportTest(input string name);
		if (testErrors == 0)
		begin
			$display("test %s passed", name);
			passCount++;
		end
		else
		begin
			$display("test %s failed with %0d errors", name, testErrors);
			failCount++;
		end
	endtask

	initial
	begin
		int fd;
		int fields;
		int a;
		int b;
		int d;
		int ox;
		int oy;
		int c;
		int recNum;
		string line;
		string op;
		pixelX = 11'd0;
		pixelY = 11'd0;
		hitStrobe = 1'b0;
		hitCol = 6'd0;
		hitRow = 5'd0;
		resetN = 1'b0;
		erasePending = 1'b0;
		pendingAddr = 0;
		passCount = 0;
		failCount = 0;
		otherErrors = 0;
		recNum = 0;
		for (int row = 0; row < gamePkg::MAP_ROWS; row++)
		begin
			for (int col = 0; col < gamePkg::MAP_COLS; col++)
			begin
				modelMap[row * gamePkg::MAP_COLS + col] = mazeStartCode(row, col);
			end
		end
		repeat (4) @(negedge clk);
		testErrors = 0;
		compareSignal("drawingRequest", drawingRequest, 0);
		compareSignal("eraseDone", eraseDone, 0);
		compareSignal("rgbOut", rgbOut, 0);
		compareSignal("offsetX", offsetX, 0);
		compareSignal("offsetY", offsetY, 0);
		reportTest("reset");
		resetN = 1'b1;

		fd = $fopen("mazeTrace.txt", "r");
		if (fd == 0)
		begin
			$display("could not open mazeTrace.txt");
			otherErrors++;
		end
		else
		begin
			while ($fgets(line, fd) != 0)
			begin
				op = "";
				fields = $sscanf(line, "%s %d %d %d %d %d %h", op, a, b, d, ox, oy, c);
				if ((fields <= 0) || (op.len() == 0) || (op.substr(0, 0) == "#"))
				begin
					continue; // blank or comment line
				end
				recNum++;
				testErrors = 0;
				if (fields != 7)
				begin
					$display("trace record %0d is malformed", recNum);
					testErrors++;
				end
				else if (op == "pixel")
				begin
					applyPixel(a, b, d, ox, oy, c);
				end
				else if (op == "hit")
				begin
					applyHit(a, b, d, ox, oy, c);
				end
				else if (op == "moveOut")
				begin
					moveOut(a, b, d, ox, oy, c);
				end
				else
				begin
					$display("trace record %0d has unknown operation %s", recNum, op);
					testErrors++;
				end
				reportTest($sformatf("%0d %s %0d %0d", recNum, op, a, b));
			end
			$fclose(fd);
		end

		otherErrors += dut_i.sva_i.assertFails;
		$display("tests passed %0d failed %0d, other errors %0d", passCount, failCount,
			otherErrors);
		if ((failCount == 0) && (otherErrors == 0) && (recNum > 0))
		begin
			$display("RESULT: PASS");
		end
		else
		begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

// File: mazeTrace.txt
# op a b draw offX offY color, all decimal except color in hex
# pixel and moveOut: a=x b=y, hit: a=col b=row with the previous pixel held
pixel 5 7 1 5 7 5b
pixel 37 45 1 5 13 5b
pixel 639 479 1 15 15 5b
pixel 630 170 1 6 10 5b
pixel 50 50 0 2 2 5b
pixel 200 300 0 8 12 5b
pixel 640 100 0 0 0 ff
pixel 100 480 0 0 0 ff
pixel 2047 2047 0 0 0 ff
pixel 104 104 1 8 8 5b
hit 6 6 1 8 8 5b
pixel 110 99 1 14 3 5b
moveOut 700 10 0 0 0 ff
pixel 104 104 0 8 8 5b
pixel 90 104 0 10 8 5b
pixel 41 40 1 9 8 5b
hit 3 3 1 9 8 5b
moveOut 0 600 0 0 0 ff
pixel 50 50 0 2 2 5b
pixel 37 45 1 5 13 5b
pixel 63 63 0 15 15 5b

// File: src.f
gamePkg.sv
tileMapRam.sv
mapArbiter.sv
brickRenderer.sv
brickEraser.sv
mazeDisplay.sv
mazeDisplay_sva.sv
mazeDisplay_tb.sv
